// ==== logic/strm_settings.svh ====
`ifndef STRM_SETTINGS_SVH
`define STRM_SETTINGS_SVH

// ----------------------------------------------------------------------
// bus widths
// ----------------------------------------------------------------------
`define STRM_DATA_W       128  // one completion beat
`define STRM_ADDR_W       32   // host byte address
`define STRM_LEN_W        32   // transfer length in bytes
`define STRM_TAG_W        8    // request tag

// ----------------------------------------------------------------------
// chunking of a transfer into host read requests
// ----------------------------------------------------------------------
`define STRM_BEAT_BYTES   16   // bytes carried by one beat
`define STRM_CHUNK_BYTES  256  // largest single read request
`define STRM_CHUNK_BEATS  16   // beats per chunk, also the depth of each buffer

// two tags give two requests in flight at the host
`define STRM_TAG_A        1
`define STRM_TAG_B        2

`endif

// ==== logic/strm_pkg.sv ====
`default_nettype none

`include "strm_settings.svh"

package strm_pkg;

  // ----------------------------------------------------------------------
  // payload and request fields
  // ----------------------------------------------------------------------
  typedef logic [`STRM_DATA_W-1:0] data_t;
  typedef logic [`STRM_ADDR_W-1:0] addr_t;
  typedef logic [`STRM_LEN_W-1:0]  len_t;
  typedef logic [`STRM_TAG_W-1:0]  tag_t;

  typedef logic [$clog2(`STRM_CHUNK_BYTES):0]                  req_len_t;  // holds a full chunk
  typedef logic [`STRM_LEN_W-$clog2(`STRM_BEAT_BYTES)-1:0]     beat_cnt_t; // beats per transfer
  typedef logic [$clog2(`STRM_CHUNK_BEATS)-1:0]                chunk_cnt_t; // beat within a chunk

  // read request sequencer
  typedef enum logic [2:0] {
    IDLE,
    REQ_A,
    WAIT_A_ACK,
    REQ_B,
    WAIT_B_ACK,
    WAIT_DONE,
    DRAIN
  } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/rd_req_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "strm_settings.svh"

module rd_req_sequencer
  import strm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     strm_en_i,
  input  addr_t    dma_src_addr_i,
  input  len_t     dma_len_i,
  output logic     dma_done_o,
  input  logic     dma_done_ack_i,
  output logic     dma_rd_req_o,
  output addr_t    dma_rd_req_addr_o,
  output req_len_t dma_rd_req_len_o,
  output tag_t     dma_tag_o,
  input  logic     dma_req_ack_i,
  input  logic     a_stored_i,
  input  logic     b_stored_i,
  input  logic     a_empty_i,
  input  logic     b_empty_i,
  output logic     restart_o
);

  localparam int   BEAT_SHIFT = $clog2(`STRM_BEAT_BYTES);
  localparam len_t CHUNK_LEN  = len_t'(`STRM_CHUNK_BYTES);

  seq_state_t state;
  len_t       rem_len;      // bytes not yet requested
  logic       last_req;     // request in flight is the final one
  beat_cnt_t  total_beats;
  beat_cnt_t  rcvd_beats;
  beat_cnt_t  a_exp;
  beat_cnt_t  a_rcv;
  beat_cnt_t  b_exp;
  beat_cnt_t  b_rcv;
  req_len_t   next_len;
  logic       next_last;
  logic       issue_a;
  logic       issue_b;

  assign next_last = (rem_len <= CHUNK_LEN);
  assign next_len  = next_last ? req_len_t'(rem_len) : req_len_t'(`STRM_CHUNK_BYTES);

  // a buffer takes a new chunk only once the old one is complete and drained
  assign issue_a = (state == REQ_A) && (a_rcv >= a_exp) && a_empty_i;
  assign issue_b = (state == REQ_B) && (b_rcv >= b_exp) && b_empty_i;

  // ----------------------------------------------------------------------
  // request and done FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      state        <= IDLE;
      dma_rd_req_o <= 1'b0;
      dma_done_o   <= 1'b0;
      restart_o    <= 1'b0;
      last_req     <= 1'b0;
    end
    else
    begin
      restart_o <= 1'b0;
      case (state)
        IDLE:
        begin
          last_req          <= 1'b0;
          rem_len           <= dma_len_i;          // latch transfer until enabled
          dma_rd_req_addr_o <= dma_src_addr_i;
          total_beats       <= beat_cnt_t'(dma_len_i >> BEAT_SHIFT);
          if (strm_en_i)
          begin
            restart_o <= 1'b1;
            state     <= (dma_len_i == '0) ? WAIT_DONE : REQ_A;  // empty transfer ends at once
          end
        end
        REQ_A, REQ_B:
        begin
          if (issue_a || issue_b)
          begin
            dma_rd_req_o     <= 1'b1;
            dma_rd_req_len_o <= next_len;
            last_req         <= next_last;
            dma_tag_o        <= issue_a ? tag_t'(`STRM_TAG_A) : tag_t'(`STRM_TAG_B);
            state            <= issue_a ? WAIT_A_ACK : WAIT_B_ACK;
          end
        end
        WAIT_A_ACK, WAIT_B_ACK:
        begin
          if (dma_req_ack_i)
          begin
            dma_rd_req_o <= 1'b0;
            if (last_req)
              state <= WAIT_DONE;
            else
            begin
              rem_len           <= rem_len - CHUNK_LEN;
              dma_rd_req_addr_o <= dma_rd_req_addr_o + addr_t'(`STRM_CHUNK_BYTES);
              state             <= (state == WAIT_A_ACK) ? REQ_B : REQ_A;  // alternate tags
            end
          end
        end
        WAIT_DONE:
        begin
          if (rcvd_beats >= total_beats)
            dma_done_o <= 1'b1;
          if (dma_done_o && !strm_en_i && dma_done_ack_i)
          begin
            dma_done_o <= 1'b0;
            state      <= DRAIN;
          end
        end
        DRAIN:
        begin
          if (a_empty_i && b_empty_i)  // user side has taken every beat
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // beat accounting per buffer and per transfer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n || (state == IDLE))
    begin
      rcvd_beats <= '0;
      a_exp      <= '0;
      a_rcv      <= '0;
      b_exp      <= '0;
      b_rcv      <= '0;
    end
    else
    begin
      rcvd_beats <= rcvd_beats + beat_cnt_t'(a_stored_i) + beat_cnt_t'(b_stored_i);
      if (issue_a)
      begin
        a_exp <= beat_cnt_t'(next_len >> BEAT_SHIFT);
        a_rcv <= '0;
      end
      else if (a_stored_i)
        a_rcv <= a_rcv + 1'b1;
      if (issue_b)
      begin
        b_exp <= beat_cnt_t'(next_len >> BEAT_SHIFT);
        b_rcv <= '0;
      end
      else if (b_stored_i)
        b_rcv <= b_rcv + 1'b1;
    end
  end

  // no new host request once the transfer has been reported done
  a_no_req_after_done: assert property (@(posedge clk_i) disable iff (!rst_n)
    $rose(dma_rd_req_o) |-> !$past(dma_done_o));

endmodule

`default_nettype wire

// ==== logic/tag_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "strm_settings.svh"

module tag_fifo
  import strm_pkg::*;
#(
  parameter tag_t TAG = tag_t'(`STRM_TAG_A)
)
(
  input  logic  clk_i,
  input  logic  rst_n,
  input  logic  dma_data_valid_i,
  input  tag_t  dma_tag_i,
  input  data_t dma_data_i,
  output logic  beat_stored_o,
  output logic  empty_o,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output data_t out_data_o
);

  localparam int FILL_W = $clog2(`STRM_CHUNK_BEATS) + 1;

  logic              hit_q;     // registered beat carries our tag
  data_t             data_q;
  data_t             mem [`STRM_CHUNK_BEATS];
  chunk_cnt_t        wr_ptr;
  chunk_cnt_t        rd_ptr;
  logic [FILL_W-1:0] fill;
  logic              rd_en;
  logic              full;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
      hit_q <= 1'b0;
    else
      hit_q <= dma_data_valid_i && (dma_tag_i == TAG);
    data_q <= dma_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (hit_q)
      mem[wr_ptr] <= data_q;
  end

  // pointers wrap at the chunk depth
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (hit_q)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      fill <= fill + FILL_W'(hit_q) - FILL_W'(rd_en);
    end
  end

  assign rd_en         = out_valid_o && out_ready_i;
  assign full          = (fill == FILL_W'(`STRM_CHUNK_BEATS));
  assign empty_o       = (fill == '0);
  assign out_valid_o   = !empty_o;
  assign out_data_o    = mem[rd_ptr];   // head of the buffer
  assign beat_stored_o = hit_q;

  // the sequencer never requests more than the buffer can hold
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n)
    hit_q |-> !full);

endmodule

`default_nettype wire

// ==== logic/stream_reorder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "strm_settings.svh"

module stream_reorder
  import strm_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n,
  input  logic  restart_i,
  input  logic  a_valid_i,
  input  logic  b_valid_i,
  input  data_t a_data_i,
  input  data_t b_data_i,
  output logic  a_ready_o,
  output logic  b_ready_o,
  output logic  stream_valid_o,
  input  logic  stream_ready_i,
  output data_t stream_data_o
);

  localparam chunk_cnt_t LAST_BEAT = chunk_cnt_t'(`STRM_CHUNK_BEATS - 1);

  logic       sel_b;      // 0 while draining buffer A
  chunk_cnt_t beat_cnt;
  logic       xfer;

  assign xfer = stream_valid_o && stream_ready_i;

  // one full chunk from each buffer in turn keeps address order
  always_ff @(posedge clk_i)
  begin
    if (!rst_n || restart_i)
    begin
      sel_b    <= 1'b0;
      beat_cnt <= '0;
    end
    else if (xfer)
    begin
      beat_cnt <= beat_cnt + 1'b1;
      if (beat_cnt == LAST_BEAT)
        sel_b <= !sel_b;
    end
  end

  assign stream_valid_o = sel_b ? b_valid_i : a_valid_i;
  assign stream_data_o  = sel_b ? b_data_i : a_data_i;
  assign a_ready_o      = !sel_b && stream_ready_i;
  assign b_ready_o      = sel_b && stream_ready_i;

  // a stalled beat must not change underneath the user
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
    stream_valid_o && !stream_ready_i |=> stream_valid_o && $stable(stream_data_o));

endmodule

`default_nettype wire

// ==== logic/sys_user_stream_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "strm_settings.svh"

module sys_user_stream_top
  import strm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n,
  // register block
  input  logic     strm_en_i,
  input  addr_t    dma_src_addr_i,
  input  len_t     dma_len_i,
  output logic     dma_done_o,
  input  logic     dma_done_ack_i,
  // host read requests
  output logic     dma_rd_req_o,
  output addr_t    dma_rd_req_addr_o,
  output req_len_t dma_rd_req_len_o,
  output tag_t     dma_tag_o,
  input  logic     dma_req_ack_i,
  // completions from the receive engine
  input  logic     dma_data_valid_i,
  input  tag_t     dma_tag_i,
  input  data_t    dma_data_i,
  // user stream
  output logic     stream_valid_o,
  input  logic     stream_ready_i,
  output data_t    stream_data_o
);

  logic  a_stored;
  logic  b_stored;
  logic  a_empty;
  logic  b_empty;
  logic  restart;
  logic  a_valid;
  logic  b_valid;
  logic  a_ready;
  logic  b_ready;
  data_t a_data;
  data_t b_data;

  // ----------------------------------------------------------------------
  // request side
  // ----------------------------------------------------------------------
  rd_req_sequencer u_seq (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .strm_en_i         (strm_en_i),
    .dma_src_addr_i    (dma_src_addr_i),
    .dma_len_i         (dma_len_i),
    .dma_done_o        (dma_done_o),
    .dma_done_ack_i    (dma_done_ack_i),
    .dma_rd_req_o      (dma_rd_req_o),
    .dma_rd_req_addr_o (dma_rd_req_addr_o),
    .dma_rd_req_len_o  (dma_rd_req_len_o),
    .dma_tag_o         (dma_tag_o),
    .dma_req_ack_i     (dma_req_ack_i),
    .a_stored_i        (a_stored),
    .b_stored_i        (b_stored),
    .a_empty_i         (a_empty),
    .b_empty_i         (b_empty),
    .restart_o         (restart)
  );

  // ----------------------------------------------------------------------
  // one buffer per tag, both see every completion
  // ----------------------------------------------------------------------
  tag_fifo #(.TAG(tag_t'(`STRM_TAG_A))) u_buf_a (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .dma_data_valid_i (dma_data_valid_i),
    .dma_tag_i        (dma_tag_i),
    .dma_data_i       (dma_data_i),
    .beat_stored_o    (a_stored),
    .empty_o          (a_empty),
    .out_valid_o      (a_valid),
    .out_ready_i      (a_ready),
    .out_data_o       (a_data)
  );

  tag_fifo #(.TAG(tag_t'(`STRM_TAG_B))) u_buf_b (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .dma_data_valid_i (dma_data_valid_i),
    .dma_tag_i        (dma_tag_i),
    .dma_data_i       (dma_data_i),
    .beat_stored_o    (b_stored),
    .empty_o          (b_empty),
    .out_valid_o      (b_valid),
    .out_ready_i      (b_ready),
    .out_data_o       (b_data)
  );

  stream_reorder u_reorder (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .restart_i      (restart),
    .a_valid_i      (a_valid),
    .b_valid_i      (b_valid),
    .a_data_i       (a_data),
    .b_data_i       (b_data),
    .a_ready_o      (a_ready),
    .b_ready_o      (b_ready),
    .stream_valid_o (stream_valid_o),
    .stream_ready_i (stream_ready_i),
    .stream_data_o  (stream_data_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_sys_user_stream.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "strm_settings.svh"

module tb_sys_user_stream
  import strm_pkg::*;
();

  localparam int NUM_ROWS = 6;

  // address, length in bytes, expected requests, out of order, stray tags, back-pressure
  localparam logic [74:0] STIM [NUM_ROWS] = '{
    {32'h0000_1000, 32'd64,   8'd1, 1'b0, 1'b0, 1'b0},   // single short request
    {32'h0002_0000, 32'd1200, 8'd5, 1'b0, 1'b0, 1'b0},   // five requests, short tail
    {32'h0003_0400, 32'd768,  8'd3, 1'b1, 1'b0, 1'b0},
    {32'h0004_0000, 32'd1008, 8'd4, 1'b0, 1'b0, 1'b1},
    {32'h0005_0100, 32'd512,  8'd2, 1'b0, 1'b1, 1'b0},
    {32'h0006_0000, 32'd896,  8'd4, 1'b1, 1'b1, 1'b1}
  };

  logic     clk_i = 1'b0;
  logic     rst_n;
  logic     strm_en_i;
  addr_t    dma_src_addr_i;
  len_t     dma_len_i;
  logic     dma_done_o;
  logic     dma_done_ack_i;
  logic     dma_rd_req_o;
  addr_t    dma_rd_req_addr_o;
  req_len_t dma_rd_req_len_o;
  tag_t     dma_tag_o;
  logic     dma_req_ack_i;
  logic     dma_data_valid_i;
  tag_t     dma_tag_i;
  data_t    dma_data_i;
  logic     stream_valid_o;
  logic     stream_ready_i;
  data_t    stream_data_o;

  int       seed = 84;
  logic     ooo_mode = 1'b0;
  logic     stray_mode = 1'b0;
  logic     bp_mode = 1'b0;
  addr_t    exp_req_addr;         // next request the host expects
  len_t     exp_req_rem = '0;
  tag_t     exp_req_tag;
  int       req_count;
  int       beats_sent;
  int       beats_left = 0;       // beats still due on the stream
  addr_t    exp_beat_addr;
  addr_t    q_addr [$];           // acknowledged requests awaiting data
  req_len_t q_len [$];
  tag_t     q_tag [$];
  logic     q_last [$];

  sys_user_stream_top uut (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .strm_en_i         (strm_en_i),
    .dma_src_addr_i    (dma_src_addr_i),
    .dma_len_i         (dma_len_i),
    .dma_done_o        (dma_done_o),
    .dma_done_ack_i    (dma_done_ack_i),
    .dma_rd_req_o      (dma_rd_req_o),
    .dma_rd_req_addr_o (dma_rd_req_addr_o),
    .dma_rd_req_len_o  (dma_rd_req_len_o),
    .dma_tag_o         (dma_tag_o),
    .dma_req_ack_i     (dma_req_ack_i),
    .dma_data_valid_i  (dma_data_valid_i),
    .dma_tag_i         (dma_tag_i),
    .dma_data_i        (dma_data_i),
    .stream_valid_o    (stream_valid_o),
    .stream_ready_i    (stream_ready_i),
    .stream_data_o     (stream_data_o)
  );

  always #4 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // error reporting and small helpers
  // ----------------------------------------------------------------------
  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  endtask

  task automatic plain_error(input string msg);
    $display("error: %s", msg);
    stop_run();
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  function automatic req_len_t chunk_len(input len_t rem);
    if (rem >= len_t'(`STRM_CHUNK_BYTES))
      return req_len_t'(`STRM_CHUNK_BYTES);
    return req_len_t'(rem);
  endfunction

  function automatic int watchdog_cycles();
    int beats = 0;
    for (int r = 0; r < NUM_ROWS; r++)
      beats += int'(STIM[r][42:11] / `STRM_BEAT_BYTES);
    return 200 + 20 * beats;
  endfunction

  // ----------------------------------------------------------------------
  // host model
  // ----------------------------------------------------------------------
  task automatic check_request();
    assert (exp_req_rem != 0) else plain_error("read request beyond the transfer length");
    assert (!dma_done_o) else plain_error("read request while dma_done_o is high");
    assert (dma_rd_req_addr_o == exp_req_addr)
      else value_error("dma_rd_req_addr_o", dma_rd_req_addr_o, exp_req_addr);
    assert (dma_rd_req_len_o == chunk_len(exp_req_rem))
      else value_error("dma_rd_req_len_o", dma_rd_req_len_o, chunk_len(exp_req_rem));
    assert (dma_tag_o == exp_req_tag) else value_error("dma_tag_o", dma_tag_o, exp_req_tag);
  endtask

  task automatic accept_request();
    req_len_t len;
    len = chunk_len(exp_req_rem);
    q_addr.push_back(exp_req_addr);
    q_len.push_back(len);
    q_tag.push_back(exp_req_tag);
    exp_req_addr = exp_req_addr + addr_t'(`STRM_CHUNK_BYTES);
    exp_req_rem  = exp_req_rem - len_t'(len);
    q_last.push_back(exp_req_rem == 0);
    exp_req_tag  = (exp_req_tag == tag_t'(`STRM_TAG_A)) ? tag_t'(`STRM_TAG_B) : tag_t'(`STRM_TAG_A);
    req_count++;
  endtask

  task automatic pop_request(input int idx, output addr_t addr, output req_len_t len,
                             output tag_t tag);
    addr = q_addr[idx];
    len  = q_len[idx];
    tag  = q_tag[idx];
    q_addr.delete(idx);
    q_len.delete(idx);
    q_tag.delete(idx);
    q_last.delete(idx);
  endtask

  task automatic send_chunk(input addr_t addr, input req_len_t len, input tag_t tag);
    int beats;
    beats = int'(len) / `STRM_BEAT_BYTES;
    for (int i = 0; i < beats; i++)
    begin
      if (($random(seed) & 7) == 0)
      begin
        dma_data_valid_i = 1'b0;  // occasional gap between beats
        next_cycle();
      end
      if (stray_mode && (i % 4 == 0))
      begin
        dma_data_valid_i = 1'b1;
        dma_tag_i        = tag_t'(3 + i);  // never tag 1 or 2
        dma_data_i       = {4{32'hDEAD_0000 + i}};
        next_cycle();
      end
      dma_data_valid_i = 1'b1;
      dma_tag_i        = tag;
      dma_data_i       = {4{addr + addr_t'(i * `STRM_BEAT_BYTES)}};
      beats_sent++;
      next_cycle();
    end
    dma_data_valid_i = 1'b0;
  endtask

  initial
  begin : host_ack
    int delay;
    dma_req_ack_i = 1'b0;
    forever
    begin
      @(negedge clk_i);
      if (rst_n && dma_rd_req_o)
      begin
        check_request();
        delay = $random(seed) & 3;
        repeat (delay)
        begin
          @(negedge clk_i);
          check_request();  // fields hold until the ack
        end
        next_cycle();
        dma_req_ack_i = 1'b1;
        next_cycle();
        dma_req_ack_i = 1'b0;
        accept_request();
      end
    end
  end

  initial
  begin : host_data
    addr_t    a0;
    addr_t    a1;
    req_len_t l0;
    req_len_t l1;
    tag_t     t0;
    tag_t     t1;
    dma_data_valid_i = 1'b0;
    dma_tag_i        = '0;
    dma_data_i       = '0;
    forever
    begin
      next_cycle();
      if (q_addr.size() >= 2 && ooo_mode)
      begin
        pop_request(1, a1, l1, t1);  // second request answered first
        pop_request(0, a0, l0, t0);
        send_chunk(a1, l1, t1);
        send_chunk(a0, l0, t0);
      end
      else if (q_addr.size() != 0 && (!ooo_mode || q_last[0]))
      begin
        pop_request(0, a0, l0, t0);
        send_chunk(a0, l0, t0);
      end
    end
  end

  initial
  begin : ready_drive
    stream_ready_i = 1'b0;
    forever
    begin
      next_cycle();
      stream_ready_i = bp_mode ? (($random(seed) & 1) != 0) : 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // stream checker, sampled at the falling edge
  // ----------------------------------------------------------------------
  initial
  begin : stream_check
    logic  stalled;
    data_t held;
    stalled = 1'b0;
    held    = '0;
    forever
    begin
      @(negedge clk_i);
      if (rst_n)
      begin
        if (stalled)
        begin
          assert (stream_valid_o) else plain_error("stream_valid_o dropped during a stall");
          assert (stream_data_o == held) else value_error("stream_data_o", stream_data_o, held);
        end
        if (stream_valid_o && stream_ready_i)
        begin
          assert (beats_left != 0) else plain_error("unexpected beat on the user stream");
          assert (stream_data_o == {4{exp_beat_addr}})
            else value_error("stream_data_o", stream_data_o, {4{exp_beat_addr}});
          exp_beat_addr = exp_beat_addr + addr_t'(`STRM_BEAT_BYTES);
          beats_left--;
        end
        stalled = stream_valid_o && !stream_ready_i;
        held    = stream_data_o;
      end
    end
  end

  initial
  begin : watchdog
    int limit;
    limit = watchdog_cycles();
    repeat (limit) @(posedge clk_i);
    plain_error("timeout, the transfers did not complete in time");
  end

  // ----------------------------------------------------------------------
  // table rows
  // ----------------------------------------------------------------------
  task automatic run_row(input int r);
    logic [74:0] row;
    int          total;
    row = STIM[r];
    next_cycle();
    total         = int'(row[42:11] / `STRM_BEAT_BYTES);
    ooo_mode      = row[2];
    stray_mode    = row[1];
    bp_mode       = row[0];
    exp_req_addr  = row[74:43];
    exp_req_rem   = row[42:11];
    exp_req_tag   = tag_t'(`STRM_TAG_A);   // every transfer starts on buffer A
    req_count     = 0;
    beats_sent    = 0;
    exp_beat_addr = row[74:43];
    beats_left    = total;
    dma_src_addr_i = row[74:43];
    dma_len_i      = row[42:11];
    strm_en_i      = 1'b1;

    while (!dma_done_o)
      @(negedge clk_i);
    assert (beats_sent == total) else plain_error("dma_done_o rose before all beats arrived");
    assert (req_count == int'(row[10:3])) else value_error("request count", req_count, row[10:3]);
    assert (exp_req_rem == 0) else value_error("bytes left unrequested", exp_req_rem, 0);

    next_cycle();
    dma_done_ack_i = 1'b1;  // ack alone must not clear done
    next_cycle();
    dma_done_ack_i = 1'b0;
    @(negedge clk_i);
    assert (dma_done_o) else plain_error("dma_done_o cleared while strm_en_i was high");
    next_cycle();
    strm_en_i = 1'b0;
    repeat (2)
    begin
      @(negedge clk_i);
      assert (dma_done_o) else plain_error("dma_done_o cleared without an ack");
    end
    next_cycle();
    dma_done_ack_i = 1'b1;
    next_cycle();
    dma_done_ack_i = 1'b0;
    @(negedge clk_i);
    assert (!dma_done_o) else plain_error("dma_done_o still high one cycle after the ack");

    while (beats_left != 0)
      @(negedge clk_i);
  endtask

  initial
  begin : main_seq
    rst_n          = 1'b0;
    strm_en_i      = 1'b0;
    dma_src_addr_i = '0;
    dma_len_i      = '0;
    dma_done_ack_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
    @(negedge clk_i);
    assert (!dma_rd_req_o && !dma_done_o && !stream_valid_o)
      else plain_error("outputs not idle after reset");
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    repeat (10) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/strm_pkg.sv
logic/rd_req_sequencer.sv
logic/tag_fifo.sv
logic/stream_reorder.sv
logic/sys_user_stream_top.sv
tb/tb_sys_user_stream.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the stream testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f \
  --top-module tb_sys_user_stream \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0
